// ==== design/ppu_macros.svh ====
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// ========================================
// Screen geometry
// ========================================

// Pixels per line (160 on the real LCD)
`define PPU_SCREEN_W       16

// Visible lines (144 on the real LCD)
`define PPU_VISIBLE_LINES  8

// Lines per frame including vblank (154 on the real LCD)
`define PPU_TOTAL_LINES    10

// ========================================
// Line timing
// ========================================

// Cycles per line (456 on the real LCD)
`define PPU_LINE_CYCLES    64

// Length of mode 2 in cycles (80 on the real LCD)
`define PPU_OAM_CYCLES     8

// ========================================
// Memory layout
// ========================================

`define PPU_VRAM_BYTES     1024
`define PPU_MAP_STRIDE     32
`define PPU_MAP_ROWS       8
`define PPU_FIFO_DEPTH     16

`endif

// ==== design/ppu_types_pkg.sv ====
package ppu_types_pkg;

  // ========================================
  // Video timing
  // ========================================

  // Line modes, encoded as reported in STAT bits 1:0
  typedef enum logic [1:0] {
    hblank   = 2'd0,
    vblank   = 2'd1,
    oam_scan = 2'd2,
    transfer = 2'd3
  } ppu_mode_t;

  // ========================================
  // Background fetcher
  // ========================================

  // Map byte, low plane, high plane, then 8 pushes into the pixel FIFO
  typedef enum logic [2:0] {
    idle,
    read_map,
    read_lo,
    read_hi,
    push
  } fetch_state_t;

  // Palette output, 0 is the lightest shade
  typedef logic [1:0] shade_t;

endpackage

// ==== design/ppu_map_pkg.sv ====
package ppu_map_pkg;

  // ========================================
  // CPU side address map
  // ========================================

  // Target of an APB address
  typedef enum logic [1:0] {
    vram,
    regs,
    none
  } ppu_region_t;

  // LCD control registers
  typedef enum logic [15:0] {
    reg_lcdc = 16'hff40,
    reg_stat = 16'hff41,
    reg_scy  = 16'hff42,
    reg_ly   = 16'hff44,
    reg_lyc  = 16'hff45,
    reg_bgp  = 16'hff47
  } ppu_reg_t;

  // VRAM window and its two background areas
  localparam logic [15:0] VRAM_BASE = 16'h8000;

  // 16 tiles of 16 bytes, two bytes per tile row
  localparam logic [15:0] TILE_BASE = 16'h8000;

  // One tile number per byte, 32 bytes per map row
  localparam logic [15:0] MAP_BASE  = 16'h8200;

endpackage

// ==== design/ppu_bus_decode.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_bus_decode
  import ppu_types_pkg::*, ppu_map_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [7:0]  pwdata,
  input  ppu_mode_t   mode,
  input  logic [7:0]  ly,
  input  logic [15:0] vram_rd_addr,
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        lcd_on,
  output logic        bg_on,
  output logic [7:0]  scy,
  output logic [7:0]  lyc,
  output logic [7:0]  bgp,
  output logic [7:0]  vram_rd_data
);

  localparam int VRAM_AW = $clog2(`PPU_VRAM_BYTES);
  localparam logic [15:0] VRAM_LAST = VRAM_BASE + 16'(`PPU_VRAM_BYTES - 1);

  logic [7:0]  vram_mem [`PPU_VRAM_BYTES];
  logic [7:0]  lcdc;
  logic [7:0]  stat;
  ppu_region_t region;
  logic        access;
  logic        wr_en;
  logic        vram_blocked;
  logic [15:0] cpu_off;
  logic [15:0] fetch_off;

  // ========================================
  // Address decode
  // ========================================

  assign access       = psel && penable;
  assign wr_en        = access && pwrite;
  assign vram_blocked = (mode == transfer);
  assign cpu_off      = paddr - VRAM_BASE;
  assign fetch_off    = vram_rd_addr - VRAM_BASE;

  always_comb begin
    if (paddr >= VRAM_BASE && paddr <= VRAM_LAST) begin
      region = vram;
    end else begin
      case (paddr)
        reg_lcdc, reg_stat, reg_scy, reg_ly, reg_lyc, reg_bgp: region = regs;
        default: region = none;
      endcase
    end
  end

  // No wait states, errors only for unmapped addresses
  assign pready  = access;
  assign pslverr = access && (region == none);

  // ========================================
  // Register file
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc <= 8'h00;
      scy  <= 8'h00;
      lyc  <= 8'h00;
      bgp  <= 8'he4;
    end else if (wr_en && region == regs) begin
      case (paddr)
        reg_lcdc: lcdc <= pwdata;
        reg_scy:  scy  <= pwdata;
        reg_lyc:  lyc  <= pwdata;
        reg_bgp:  bgp  <= pwdata;
        // STAT and LY are read-only
        default: ;
      endcase
    end
  end

  assign lcd_on = lcdc[7];
  assign bg_on  = lcdc[0];

  // Coincidence flag next to the current mode
  assign stat = {5'b00000, ly == lyc, mode};

  // ========================================
  // VRAM
  // ========================================

  // CPU writes are lost while the fetcher owns VRAM
  always_ff @(posedge clk) begin
    if (wr_en && region == vram && !vram_blocked) begin
      vram_mem[cpu_off[VRAM_AW-1:0]] <= pwdata;
    end
  end

  assign vram_rd_data = vram_mem[fetch_off[VRAM_AW-1:0]];

  // Read data, FF for anything unmapped or blocked
  always_comb begin
    prdata = 8'hff;
    if (psel && !pwrite) begin
      case (region)
        vram: begin
          if (!vram_blocked) begin
            prdata = vram_mem[cpu_off[VRAM_AW-1:0]];
          end
        end
        regs: begin
          case (paddr)
            reg_lcdc: prdata = lcdc;
            reg_stat: prdata = stat;
            reg_scy:  prdata = scy;
            reg_ly:   prdata = ly;
            reg_lyc:  prdata = lyc;
            reg_bgp:  prdata = bgp;
            default:  prdata = 8'hff;
          endcase
        end
        default: prdata = 8'hff;
      endcase
    end
  end

endmodule

// ==== design/ppu_mode_timer.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_mode_timer
  import ppu_types_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       lcd_on,
  input  logic       line_done,
  output ppu_mode_t  mode,
  output logic [7:0] ly,
  output logic       vblank_irq
);

  localparam int CW = $clog2(`PPU_LINE_CYCLES);
  localparam logic [CW-1:0] LAST_CYCLE   = CW'(`PPU_LINE_CYCLES - 1);
  localparam logic [CW-1:0] OAM_LAST     = CW'(`PPU_OAM_CYCLES - 1);
  localparam logic [7:0]    LAST_VISIBLE = 8'(`PPU_VISIBLE_LINES - 1);
  localparam logic [7:0]    LAST_LINE    = 8'(`PPU_TOTAL_LINES - 1);

  // Cycle position within the current line
  logic [CW-1:0] line_cycle;
  logic          line_end;

  assign line_end = (line_cycle == LAST_CYCLE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode       <= oam_scan;
      ly         <= 8'd0;
      line_cycle <= '0;
      vblank_irq <= 1'b0;
    end else if (!lcd_on) begin
      // LCD off parks the sequencer at the top of the frame
      mode       <= oam_scan;
      ly         <= 8'd0;
      line_cycle <= '0;
      vblank_irq <= 1'b0;
    end else begin
      vblank_irq <= 1'b0;
      line_cycle <= line_end ? '0 : line_cycle + 1'b1;

      case (mode)
        oam_scan: begin
          if (line_cycle == OAM_LAST) begin
            mode <= transfer;
          end
        end

        // Length set by the pixel pipeline
        transfer: begin
          if (line_done) begin
            mode <= hblank;
          end
        end

        hblank: begin
          if (line_end) begin
            ly <= ly + 8'd1;
            if (ly == LAST_VISIBLE) begin
              mode       <= vblank;
              vblank_irq <= 1'b1;
            end else begin
              mode <= oam_scan;
            end
          end
        end

        vblank: begin
          if (line_end) begin
            if (ly == LAST_LINE) begin
              ly   <= 8'd0;
              mode <= oam_scan;
            end else begin
              ly <= ly + 8'd1;
            end
          end
        end

        default: mode <= oam_scan;
      endcase
    end
  end

endmodule

// ==== design/ppu_bg_fetcher.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_bg_fetcher
  import ppu_types_pkg::*, ppu_map_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ppu_mode_t   mode,
  input  logic [7:0]  ly,
  input  logic [7:0]  scy,
  input  logic [7:0]  vram_rd_data,
  input  logic        fifo_full,
  output logic [15:0] vram_rd_addr,
  output logic        push,
  output logic [1:0]  push_index
);

  localparam int TILES = `PPU_SCREEN_W / 8;
  localparam int TW    = $clog2(TILES + 1);
  localparam int ROW_W = $clog2(`PPU_MAP_ROWS);
  localparam logic [TW-1:0] LAST_COL = TW'(TILES - 1);
  localparam logic [TW-1:0] DONE_COL = TW'(TILES);

  fetch_state_t   state;
  logic [TW-1:0]  tile_col;
  logic [2:0]     bit_cnt;
  logic [7:0]     line_y;
  logic [ROW_W-1:0] map_row;
  logic [2:0]     fine_row;
  logic [3:0]     tile_num;
  logic [7:0]     lo_bits;
  logic [7:0]     hi_bits;

  // Background line after vertical scroll, wraps around the map
  assign line_y   = ly + scy;
  assign map_row  = line_y[ROW_W+2:3];
  assign fine_row = line_y[2:0];

  // ========================================
  // VRAM addressing
  // ========================================

  always_comb begin
    case (state)
      read_lo: vram_rd_addr = TILE_BASE + 16'({tile_num, fine_row, 1'b0});
      read_hi: vram_rd_addr = TILE_BASE + 16'({tile_num, fine_row, 1'b1});
      default: vram_rd_addr = MAP_BASE + 16'(map_row * `PPU_MAP_STRIDE) + 16'(tile_col);
    endcase
  end

  // Leftmost pixel sits in bit 7 of both planes
  assign push       = (state == ppu_types_pkg::push) && !fifo_full && (mode == transfer);
  assign push_index = {hi_bits[7], lo_bits[7]};

  // ========================================
  // Fetch FSM
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= idle;
      tile_col <= '0;
      bit_cnt  <= 3'd0;
    end else if (mode != transfer) begin
      state    <= idle;
      tile_col <= '0;
      bit_cnt  <= 3'd0;
    end else begin
      case (state)
        idle: begin
          if (tile_col != DONE_COL) begin
            state <= read_map;
          end
        end
        read_map: state <= read_lo;
        read_lo:  state <= read_hi;
        read_hi:  state <= ppu_types_pkg::push;
        ppu_types_pkg::push: begin
          if (push) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              tile_col <= tile_col + 1'b1;
              state    <= (tile_col == LAST_COL) ? idle : read_map;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Tile number and plane shifters
  always_ff @(posedge clk) begin
    case (state)
      read_map: tile_num <= vram_rd_data[3:0];
      read_lo:  lo_bits  <= vram_rd_data;
      read_hi:  hi_bits  <= vram_rd_data;
      ppu_types_pkg::push: begin
        if (push) begin
          lo_bits <= lo_bits << 1;
          hi_bits <= hi_bits << 1;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== design/ppu_pixel_out.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_pixel_out
  import ppu_types_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ppu_mode_t  mode,
  input  logic [7:0] ly,
  input  logic       bg_on,
  input  logic [7:0] bgp,
  input  logic       push,
  input  logic [1:0] push_index,
  output logic       fifo_full,
  output logic       line_done,
  output logic       pix_valid,
  output logic [7:0] pix_x,
  output logic [7:0] pix_y,
  output shade_t     pix_shade
);

  localparam int DEPTH = `PPU_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CNTW  = PW + 1;
  localparam logic [7:0] LINE_W = 8'(`PPU_SCREEN_W);

  logic [1:0]      fifo_mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CNTW-1:0] count;
  logic [7:0]      x_cnt;
  logic            active;
  logic            wr;
  logic            pop;
  logic [1:0]      head;

  assign active    = (mode == transfer);
  assign fifo_full = (count == CNTW'(DEPTH));
  assign wr        = push && !fifo_full && active;
  // One pop per cycle until the line is complete
  assign pop       = active && (count != '0) && (x_cnt != LINE_W);
  assign head      = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr) begin
      fifo_mem[wr_ptr] <= push_index;
    end
  end

  // ========================================
  // FIFO control and line position
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      x_cnt     <= 8'd0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else if (!active) begin
      // Flush between lines and while the LCD is off
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      x_cnt     <= 8'd0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        x_cnt  <= x_cnt + 8'd1;
      end
      count     <= count + CNTW'(wr) - CNTW'(pop);
      pix_valid <= pop;
      line_done <= pop && (x_cnt == LINE_W - 8'd1);
    end
  end

  // Palette lookup, background disabled gives the lightest shade
  always_ff @(posedge clk) begin
    if (pop) begin
      pix_x     <= x_cnt;
      pix_y     <= ly;
      pix_shade <= bg_on ? shade_t'(bgp[head*2 +: 2]) : shade_t'(2'b00);
    end
  end

endmodule

// ==== design/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top
  import ppu_types_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [7:0]  pwdata,
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        pix_valid,
  output logic [7:0]  pix_x,
  output logic [7:0]  pix_y,
  output shade_t      pix_shade,
  output logic        vblank_irq
);

  // ========================================
  // Internal nets
  // ========================================

  logic        lcd_on;
  logic        bg_on;
  logic [7:0]  scy;
  logic [7:0]  bgp;
  ppu_mode_t   mode;
  logic [7:0]  ly;
  logic [15:0] vram_rd_addr;
  logic [7:0]  vram_rd_data;
  logic        push;
  logic [1:0]  push_index;
  logic        fifo_full;
  logic        line_done;

  // CPU port, registers and VRAM
  ppu_bus_decode ppu_bus_decode_inst (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .mode         (mode),
    .ly           (ly),
    .vram_rd_addr (vram_rd_addr),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .lcd_on       (lcd_on),
    .bg_on        (bg_on),
    .scy          (scy),
    .lyc          (),
    .bgp          (bgp),
    .vram_rd_data (vram_rd_data)
  );

  ppu_mode_timer ppu_mode_timer_inst (
    .clk        (clk),
    .reset      (reset),
    .lcd_on     (lcd_on),
    .line_done  (line_done),
    .mode       (mode),
    .ly         (ly),
    .vblank_irq (vblank_irq)
  );

  ppu_bg_fetcher ppu_bg_fetcher_inst (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .ly           (ly),
    .scy          (scy),
    .vram_rd_data (vram_rd_data),
    .fifo_full    (fifo_full),
    .vram_rd_addr (vram_rd_addr),
    .push         (push),
    .push_index   (push_index)
  );

  ppu_pixel_out ppu_pixel_out_inst (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .bg_on      (bg_on),
    .bgp        (bgp),
    .push       (push),
    .push_index (push_index),
    .fifo_full  (fifo_full),
    .line_done  (line_done),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_shade  (pix_shade)
  );

endmodule

// ==== bench/ppu_assert.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_assert
  import ppu_types_pkg::*, ppu_map_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input ppu_mode_t   mode,
  input logic        vblank_irq,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [15:0] paddr,
  input logic [7:0]  prdata,
  input logic        pslverr
);

  // Transfer must end in time to leave at least one hblank cycle
  localparam int XFER_MAX = `PPU_LINE_CYCLES - `PPU_OAM_CYCLES - 1;

  int failures = 0;
  int xfer_len;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      xfer_len <= 0;
    end else if (mode == transfer) begin
      xfer_len <= xfer_len + 1;
    end else begin
      xfer_len <= 0;
    end
  end

  irq_one_cycle: assert property (@(posedge clk) disable iff (reset)
    vblank_irq |=> !vblank_irq)
    else begin
      $error("vblank_irq held for more than one cycle");
      failures++;
    end

  transfer_fits_line: assert property (@(posedge clk) disable iff (reset)
    mode == transfer |-> xfer_len < XFER_MAX)
    else begin
      $error("transfer mode reached the end of the line");
      failures++;
    end

  slverr_in_access: assert property (@(posedge clk) disable iff (reset)
    pslverr |-> psel && penable)
    else begin
      $error("pslverr high outside an access phase");
      failures++;
    end

  // Fetcher owns VRAM during transfer
  vram_read_blocked: assert property (@(posedge clk) disable iff (reset)
    psel && penable && !pwrite && mode == transfer && paddr >= VRAM_BASE &&
    paddr < VRAM_BASE + `PPU_VRAM_BYTES |-> prdata == 8'hff)
    else begin
      $error("VRAM read during transfer did not return FF");
      failures++;
    end

endmodule

bind ppu_top ppu_assert ppu_assert_inst (
  .clk        (clk),
  .reset      (reset),
  .mode       (mode),
  .vblank_irq (vblank_irq),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .prdata     (prdata),
  .pslverr    (pslverr)
);

// ==== bench/ppu_tb.sv ====
`timescale 1ns/1ps

`include "ppu_macros.svh"

module ppu_tb
  import ppu_types_pkg::*, ppu_map_pkg::*;
();

  localparam int FRAME_PIXELS = `PPU_SCREEN_W * `PPU_VISIBLE_LINES;
  localparam int FRAME_CYCLES = `PPU_LINE_CYCLES * `PPU_TOTAL_LINES;
  localparam int MAP_OFF      = int'(MAP_BASE - VRAM_BASE);
  localparam int TILE_OFF     = int'(TILE_BASE - VRAM_BASE);

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_valid;
  logic [7:0]  pix_x;
  logic [7:0]  pix_y;
  shade_t      pix_shade;
  logic        vblank_irq;

  // Reference copy of VRAM and of the registers that shape the picture
  logic [7:0]  vram_model [`PPU_VRAM_BYTES];
  logic [7:0]  scy_model;
  logic [7:0]  bgp_model;
  logic        bg_on_model;

  logic [7:0]  rd_data;
  logic        rd_err;
  int          errors;
  int          checks;
  int          exp_x;
  int          exp_y;
  int          pix_since_irq;
  int          irq_count;
  int          first_x;
  int          first_y;

  ppu_top ppu_top_inst (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_shade  (pix_shade),
    .vblank_irq (vblank_irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // Reference model and checking
  // ========================================

  // Background pixel after vertical scroll, tile lookup and palette
  function automatic logic [1:0] expected_shade(int x, int y);
    logic [7:0] line_y;
    int         tile;
    int         base;
    int         b;
    logic [1:0] idx;
    line_y = 8'(y) + scy_model;
    tile   = int'(vram_model[MAP_OFF + int'(line_y[5:3]) * `PPU_MAP_STRIDE + x / 8][3:0]);
    base   = TILE_OFF + tile * 16 + int'(line_y[2:0]) * 2;
    b      = 7 - x % 8;
    idx    = {vram_model[base + 1][b], vram_model[base][b]};
    return bg_on_model ? bgp_model[int'(idx) * 2 +: 2] : 2'b00;
  endfunction

  task automatic check_equal(string name, int actual, int expected);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    int total;
    total = errors + ppu_top_inst.ppu_assert_inst.failures;
    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, ppu_top_inst.ppu_assert_inst.failures);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(string what);
    errors++;
    $display("Timed out waiting for %s at %0t", what, $time);
    finish_run();
  endtask

  // Pixels and interrupts are sampled half a cycle after they change
  always @(negedge clk) begin
    if (!reset && pix_valid) begin
      if (pix_since_irq == 0) begin
        first_x = pix_x;
        first_y = pix_y;
      end
      check_equal("pix_x", pix_x, exp_x);
      check_equal("pix_y", pix_y, exp_y);
      check_equal("pix_shade", pix_shade, expected_shade(exp_x, exp_y));
      pix_since_irq++;
      exp_x++;
      if (exp_x == `PPU_SCREEN_W) begin
        exp_x = 0;
        exp_y = (exp_y + 1) % `PPU_VISIBLE_LINES;
      end
    end
    if (!reset && vblank_irq) begin
      check_equal("pixels per vblank_irq", pix_since_irq, FRAME_PIXELS);
      pix_since_irq = 0;
      irq_count++;
    end
  end

  // ========================================
  // APB and LCD control
  // ========================================

  task automatic apb_access(logic write, logic [15:0] addr, logic [7:0] data);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    n = 0;
    while (!pready && n < 20) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!pready) begin
      fail_timeout("pready");
    end
    rd_data = prdata;
    rd_err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_roundtrip(string name, logic [15:0] addr, logic [7:0] val);
    apb_access(1'b1, addr, val);
    apb_access(1'b0, addr, 8'h00);
    check_equal(name, rd_data, val);
  endtask

  // Frame starts over at line 0, so the expected raster does too
  task automatic enable_lcd(logic bg);
    exp_x         = 0;
    exp_y         = 0;
    pix_since_irq = 0;
    first_x       = -1;
    first_y       = -1;
    bg_on_model   = bg;
    apb_access(1'b1, reg_lcdc, {1'b1, 6'b000000, bg});
  endtask

  // Keeps bit 0 so pixels still draining match the model
  task automatic disable_lcd();
    apb_access(1'b1, reg_lcdc, {7'b0000000, bg_on_model});
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_frames(int n);
    int target;
    int cycles;
    target = irq_count + n;
    cycles = 0;
    while (irq_count < target && cycles < n * FRAME_CYCLES + 2 * `PPU_LINE_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (irq_count < target) begin
      fail_timeout("vblank_irq");
    end
  endtask

  task automatic wait_pixels(int k);
    int cycles;
    cycles = 0;
    while (pix_since_irq < k && cycles < FRAME_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (pix_since_irq < k) begin
      fail_timeout("pixels");
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [7:0]  val;
    logic [15:0] addr;
    void'($urandom(32'h56e9));
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 16'h0000;
    pwdata      = 8'h00;
    errors      = 0;
    checks      = 0;
    irq_count   = 0;
    exp_x       = 0;
    exp_y       = 0;
    scy_model   = 8'h00;
    bgp_model   = 8'he4;
    bg_on_model = 1'b0;
    pix_since_irq = 0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // Registers, LCD bit held low
    reg_roundtrip("LCDC", reg_lcdc, 8'($urandom) & 8'h7f);
    reg_roundtrip("SCY", reg_scy, 8'($urandom));
    reg_roundtrip("LYC", reg_lyc, 8'($urandom));
    reg_roundtrip("BGP", reg_bgp, 8'($urandom));
    apb_access(1'b1, reg_ly, 8'($urandom));
    apb_access(1'b0, reg_ly, 8'h00);
    check_equal("LY", rd_data, 0);
    addr = 16'h8400 + 16'($urandom % 32'h7000);
    apb_access(1'b0, addr, 8'h00);
    check_equal("unmapped prdata", rd_data, 8'hff);
    check_equal("unmapped pslverr", rd_err, 1);

    // Whole VRAM
    for (int i = 0; i < `PPU_VRAM_BYTES; i++) begin
      vram_model[i] = 8'($urandom);
      apb_access(1'b1, VRAM_BASE + 16'(i), vram_model[i]);
    end
    for (int i = 0; i < `PPU_VRAM_BYTES; i++) begin
      apb_access(1'b0, VRAM_BASE + 16'(i), 8'h00);
      check_equal("VRAM readback", rd_data, vram_model[i]);
    end

    // LY compare flag
    apb_access(1'b0, reg_ly, 8'h00);
    val = rd_data;
    apb_access(1'b1, reg_lyc, val);
    apb_access(1'b0, reg_stat, 8'h00);
    check_equal("STAT coincidence", rd_data[2], 1);
    check_equal("STAT mode", rd_data[1:0], oam_scan);

    // Two scrolled frames, with CPU reads racing the fetcher
    scy_model = 8'($urandom);
    bgp_model = 8'($urandom);
    apb_access(1'b1, reg_scy, scy_model);
    apb_access(1'b1, reg_bgp, bgp_model);
    enable_lcd(1'b1);
    for (int i = 0; i < 16; i++) begin
      addr = VRAM_BASE + 16'($urandom % `PPU_VRAM_BYTES);
      apb_access(1'b0, addr, 8'h00);
      if (rd_data != 8'hff) begin
        check_equal("VRAM read while on", rd_data, vram_model[int'(addr - VRAM_BASE)]);
      end
    end
    wait_frames(2);

    // Background layer off
    disable_lcd();
    enable_lcd(1'b0);
    wait_frames(1);

    // Restart in the middle of a frame
    disable_lcd();
    enable_lcd(1'b1);
    wait_pixels(10 + int'($urandom % 100));
    disable_lcd();
    enable_lcd(1'b1);
    wait_pixels(1);
    check_equal("first pix_x", first_x, 0);
    check_equal("first pix_y", first_y, 0);
    wait_frames(1);

    finish_run();
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/ppu_types_pkg.sv
design/ppu_map_pkg.sv
design/ppu_bus_decode.sv
design/ppu_mode_timer.sv
design/ppu_bg_fetcher.sv
design/ppu_pixel_out.sv
design/ppu_top.sv
bench/ppu_assert.sv
bench/ppu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ppu_tb \
  -f filelist.f -o ppu_sim

sim_out=$(./obj_dir/ppu_sim) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1
